// ==== cpu_macros.svh ====
// --------------------------------------------------
// CPU widths, reset vector and RV32I opcode values
// --------------------------------------------------
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define CPU_XLEN     32
`define CPU_RADDR_W  5
`define CPU_RESET_PC 32'h00400000  // start of text segment

// opcodes of the supported instruction classes
`define OP_LOAD      7'd3
`define OP_STORE     7'd35
`define OP_RTYPE     7'd51
`define OP_ITYPE     7'd19
`define OP_BRANCH    7'd99

`endif

// ==== cpuPkg.sv ====
// --------------------------------------------------
// CPU types shared by the pipeline stages
// --------------------------------------------------
`include "cpu_macros.svh"

package cpuPkg;

    typedef logic [`CPU_XLEN-1:0]    wordT;     // data, address or instruction
    typedef logic [`CPU_RADDR_W-1:0] regAddrT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpT;

    typedef enum logic [1:0] {
        immI,
        immS,
        immB
    } immKindT;

    // 00 register file, 01 writeback, 10 memory stage
    typedef logic [1:0] fwdSelT;

endpackage : cpuPkg

// ==== pipeControl.sv ====
// --------------------------------------------------
// pipeControl: instruction decode, control pipeline,
// forwarding selects, load-use stall, branch flush
// --------------------------------------------------
`timescale 1ns/1ps
`include "cpu_macros.svh"

module pipeControl (
    input  logic             clk,
    input  logic             rst,
    input  cpuPkg::wordT     instrD,
    input  logic             zeroE,
    input  cpuPkg::regAddrT  rs1E,
    input  cpuPkg::regAddrT  rs2E,
    input  cpuPkg::regAddrT  rdE,
    input  cpuPkg::regAddrT  rdM,
    input  cpuPkg::regAddrT  rdW,
    output cpuPkg::immKindT  immKind,
    output cpuPkg::aluOpT    aluOp,
    output logic             aluSrcImm,
    output logic             memWrite,
    output logic             memToRegW,
    output logic             regWriteW,
    output logic             stallF,
    output logic             stallD,
    output logic             flushD,
    output logic             flushE,
    output logic             branchTaken,
    output cpuPkg::fwdSelT   fwdA,
    output cpuPkg::fwdSelT   fwdB
);

    logic [6:0]      opD;
    logic [2:0]      funct3D;
    cpuPkg::regAddrT rs1D, rs2D;
    logic            regWriteD, memToRegD, memWriteD, branchD, aluSrcImmD, aluFunctD;
    cpuPkg::aluOpT   aluOpD;
    logic            regWriteE, memToRegE, memWriteE, branchE;
    logic            regWriteM, memToRegM;
    logic            lwStall;

    assign opD     = instrD[6:0];
    assign funct3D = instrD[14:12];
    assign rs1D    = instrD[19:15];
    assign rs2D    = instrD[24:20];

    // main decoder, all-zero bubble falls to default
    always_comb begin
        regWriteD  = 1'b0;
        memToRegD  = 1'b0;
        memWriteD  = 1'b0;
        branchD    = 1'b0;
        aluSrcImmD = 1'b0;
        aluFunctD  = 1'b0;
        immKind    = cpuPkg::immI;
        case (opD)
            `OP_LOAD: begin
                regWriteD  = 1'b1;
                memToRegD  = 1'b1;
                aluSrcImmD = 1'b1;
            end
            `OP_STORE: begin
                memWriteD  = 1'b1;
                aluSrcImmD = 1'b1;
                immKind    = cpuPkg::immS;
            end
            `OP_RTYPE: begin
                regWriteD = 1'b1;
                aluFunctD = 1'b1;
            end
            `OP_ITYPE: begin
                regWriteD  = 1'b1;
                aluSrcImmD = 1'b1;
                aluFunctD  = 1'b1;
            end
            `OP_BRANCH: begin
                branchD = 1'b1;
                immKind = cpuPkg::immB;
            end
            default: ;
        endcase
    end

    // ALU decoder
    always_comb begin
        aluOpD = cpuPkg::aluAdd;                  // address calculation
        if (branchD) begin
            aluOpD = cpuPkg::aluSub;              // beq compares via zero flag
        end else if (aluFunctD) begin
            case (funct3D)
                3'b000:  aluOpD = (opD == `OP_RTYPE && instrD[30]) ? cpuPkg::aluSub
                                                                   : cpuPkg::aluAdd;
                3'b010:  aluOpD = cpuPkg::aluSlt;
                3'b110:  aluOpD = cpuPkg::aluOr;
                3'b111:  aluOpD = cpuPkg::aluAnd;
                default: aluOpD = cpuPkg::aluAdd;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flushE) begin
            regWriteE <= 1'b0;
            memToRegE <= 1'b0;
            memWriteE <= 1'b0;
            branchE   <= 1'b0;
            aluSrcImm <= 1'b0;
            aluOp     <= cpuPkg::aluAdd;
        end else begin
            regWriteE <= regWriteD;
            memToRegE <= memToRegD;
            memWriteE <= memWriteD;
            branchE   <= branchD;
            aluSrcImm <= aluSrcImmD;
            aluOp     <= aluOpD;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            regWriteM <= 1'b0;
            memToRegM <= 1'b0;
            memWrite  <= 1'b0;
            regWriteW <= 1'b0;
            memToRegW <= 1'b0;
        end else begin
            regWriteM <= regWriteE;
            memToRegM <= memToRegE;
            memWrite  <= memWriteE;
            regWriteW <= regWriteM;
            memToRegW <= memToRegM;
        end
    end

    function automatic cpuPkg::fwdSelT fwdFor(input cpuPkg::regAddrT rs);
        cpuPkg::fwdSelT sel;
        sel = 2'b00;
        if (rs != '0 && regWriteM && rs == rdM)      sel = 2'b10;
        else if (rs != '0 && regWriteW && rs == rdW) sel = 2'b01;
        return sel;
    endfunction

    assign fwdA = fwdFor(rs1E);
    assign fwdB = fwdFor(rs2E);

    // load in execute feeding decode waits one cycle
    assign lwStall     = memToRegE && rdE != '0 && (rdE == rs1D || rdE == rs2D);
    assign branchTaken = branchE && zeroE;

    assign stallF = lwStall;
    assign stallD = lwStall;
    assign flushD = branchTaken;
    assign flushE = lwStall || branchTaken;

endmodule : pipeControl

// ==== fetchStage.sv ====
// --------------------------------------------------
// fetchStage: program counter and fetch/decode register
// --------------------------------------------------
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetchStage (
    input  logic          clk,
    input  logic          rst,
    input  logic          stallF,
    input  logic          stallD,
    input  logic          flushD,
    input  logic          branchTaken,
    input  cpuPkg::wordT  branchTarget,
    input  cpuPkg::wordT  instr,
    output cpuPkg::wordT  pcF,
    output cpuPkg::wordT  pcD,
    output cpuPkg::wordT  instrD
);

    cpuPkg::wordT pcNext;

    assign pcNext = branchTaken ? branchTarget : pcF + `CPU_XLEN'd4;

    always_ff @(posedge clk) begin
        if (rst)          pcF <= `CPU_RESET_PC;
        else if (!stallF) pcF <= pcNext;
    end

    always_ff @(posedge clk) begin
        if (rst || flushD) instrD <= '0;   // bubble
        else if (!stallD)  instrD <= instr;
    end

    always_ff @(posedge clk) begin
        if (!stallD) pcD <= pcF;
    end

endmodule : fetchStage

// ==== decodeStage.sv ====
// --------------------------------------------------
// decodeStage: register file, immediate extension
// and the decode/execute register
// --------------------------------------------------
`timescale 1ns/1ps
`include "cpu_macros.svh"

module decodeStage (
    input  logic             clk,
    input  logic             rst,
    input  logic             flushE,
    input  cpuPkg::wordT     instrD,
    input  cpuPkg::wordT     pcD,
    input  cpuPkg::immKindT  immKind,
    input  logic             regWriteW,
    input  cpuPkg::regAddrT  rdW,
    input  cpuPkg::wordT     resultW,
    output cpuPkg::wordT     rd1E,
    output cpuPkg::wordT     rd2E,
    output cpuPkg::wordT     immE,
    output cpuPkg::wordT     pcE,
    output cpuPkg::regAddrT  rs1E,
    output cpuPkg::regAddrT  rs2E,
    output cpuPkg::regAddrT  rdE
);

    cpuPkg::wordT    regs [32];
    cpuPkg::regAddrT rs1D, rs2D;
    cpuPkg::wordT    rd1D, rd2D, immD;

    assign rs1D = instrD[19:15];
    assign rs2D = instrD[24:20];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (regWriteW && rdW != '0) begin
            regs[rdW] <= resultW;
        end
    end

    // x0 reads zero, same-cycle write bypasses the array
    assign rd1D = (rs1D == '0) ? '0 : (regWriteW && rdW == rs1D) ? resultW : regs[rs1D];
    assign rd2D = (rs2D == '0) ? '0 : (regWriteW && rdW == rs2D) ? resultW : regs[rs2D];

    always_comb begin
        case (immKind)
            cpuPkg::immS: immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            cpuPkg::immB: immD = {{20{instrD[31]}}, instrD[7], instrD[30:25],
                                  instrD[11:8], 1'b0};
            default:      immD = {{20{instrD[31]}}, instrD[31:20]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flushE) begin
            rs1E <= '0;
            rs2E <= '0;
            rdE  <= '0;
        end else begin
            rs1E <= rs1D;
            rs2E <= rs2D;
            rdE  <= instrD[11:7];
        end
    end

    always_ff @(posedge clk) begin
        rd1E <= rd1D;
        rd2E <= rd2D;
        immE <= immD;
        pcE  <= pcD;
    end

endmodule : decodeStage

// ==== executeStage.sv ====
// --------------------------------------------------
// executeStage: operand forwarding, ALU, branch target,
// execute/memory and memory/writeback registers
// --------------------------------------------------
`timescale 1ns/1ps
`include "cpu_macros.svh"

module executeStage (
    input  logic             clk,
    input  logic             rst,
    input  cpuPkg::wordT     rd1E,
    input  cpuPkg::wordT     rd2E,
    input  cpuPkg::wordT     immE,
    input  cpuPkg::wordT     pcE,
    input  cpuPkg::regAddrT  rdE,
    input  cpuPkg::aluOpT    aluOp,
    input  logic             aluSrcImm,
    input  cpuPkg::fwdSelT   fwdA,
    input  cpuPkg::fwdSelT   fwdB,
    input  logic             memToRegW,
    input  cpuPkg::wordT     readData,
    output logic             zeroE,
    output cpuPkg::wordT     branchTarget,
    output cpuPkg::wordT     aluResultM,
    output cpuPkg::wordT     writeDataM,
    output cpuPkg::regAddrT  rdM,
    output cpuPkg::regAddrT  rdW,
    output cpuPkg::wordT     resultW
);

    cpuPkg::wordT srcA, srcB, writeDataE, aluResultE;
    cpuPkg::wordT aluResultW, readDataW;

    always_comb begin
        case (fwdA)
            2'b01:   srcA = resultW;
            2'b10:   srcA = aluResultM;
            default: srcA = rd1E;
        endcase
        case (fwdB)
            2'b01:   writeDataE = resultW;
            2'b10:   writeDataE = aluResultM;
            default: writeDataE = rd2E;
        endcase
    end

    assign srcB = aluSrcImm ? immE : writeDataE;

    always_comb begin
        case (aluOp)
            cpuPkg::aluSub: aluResultE = srcA - srcB;
            cpuPkg::aluAnd: aluResultE = srcA & srcB;
            cpuPkg::aluOr:  aluResultE = srcA | srcB;
            cpuPkg::aluSlt: aluResultE = {{(`CPU_XLEN-1){1'b0}},
                                          $signed(srcA) < $signed(srcB)};
            default:        aluResultE = srcA + srcB;
        endcase
    end

    assign zeroE        = (aluResultE == '0);
    assign branchTarget = pcE + immE;

    always_ff @(posedge clk) begin
        if (rst) begin
            rdM <= '0;
            rdW <= '0;
        end else begin
            rdM <= rdE;
            rdW <= rdM;
        end
    end

    always_ff @(posedge clk) begin
        aluResultM <= aluResultE;
        writeDataM <= writeDataE;     // store data, already forwarded
        aluResultW <= aluResultM;
        readDataW  <= readData;
    end

    assign resultW = memToRegW ? readDataW : aluResultW;

endmodule : executeStage

// ==== cpuCore.sv ====
// --------------------------------------------------
// cpuCore: five-stage pipelined RV32I subset core
// memories sit outside and answer combinationally
// --------------------------------------------------
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpuCore (
    input  logic             clk,
    input  logic             rst,
    input  cpuPkg::wordT     instr,
    input  cpuPkg::wordT     readData,
    output cpuPkg::wordT     pc,
    output cpuPkg::wordT     aluResult,
    output cpuPkg::wordT     writeData,
    output logic             memWrite,
    output logic             wbValid,
    output cpuPkg::regAddrT  wbRd,
    output cpuPkg::wordT     wbData
);

    cpuPkg::wordT    pcD, instrD, pcE;
    cpuPkg::wordT    rd1E, rd2E, immE;
    cpuPkg::wordT    branchTarget;
    cpuPkg::regAddrT rs1E, rs2E, rdE, rdM;
    cpuPkg::immKindT immKind;
    cpuPkg::aluOpT   aluOp;
    cpuPkg::fwdSelT  fwdA, fwdB;
    logic            aluSrcImm, memToRegW, zeroE;
    logic            stallF, stallD, flushD, flushE, branchTaken;

    // wbValid, wbRd and wbData double as the writeback nets
    pipeControl u_ctrl (
        .clk(clk), .rst(rst), .instrD(instrD), .zeroE(zeroE),
        .rs1E(rs1E), .rs2E(rs2E), .rdE(rdE), .rdM(rdM), .rdW(wbRd),
        .immKind(immKind), .aluOp(aluOp), .aluSrcImm(aluSrcImm),
        .memWrite(memWrite), .memToRegW(memToRegW), .regWriteW(wbValid),
        .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE),
        .branchTaken(branchTaken), .fwdA(fwdA), .fwdB(fwdB)
    );

    fetchStage u_fetch (
        .clk(clk), .rst(rst), .stallF(stallF), .stallD(stallD),
        .flushD(flushD), .branchTaken(branchTaken),
        .branchTarget(branchTarget), .instr(instr),
        .pcF(pc), .pcD(pcD), .instrD(instrD)
    );

    decodeStage u_decode (
        .clk(clk), .rst(rst), .flushE(flushE), .instrD(instrD), .pcD(pcD),
        .immKind(immKind), .regWriteW(wbValid), .rdW(wbRd), .resultW(wbData),
        .rd1E(rd1E), .rd2E(rd2E), .immE(immE), .pcE(pcE),
        .rs1E(rs1E), .rs2E(rs2E), .rdE(rdE)
    );

    executeStage u_exec (
        .clk(clk), .rst(rst), .rd1E(rd1E), .rd2E(rd2E), .immE(immE),
        .pcE(pcE), .rdE(rdE), .aluOp(aluOp), .aluSrcImm(aluSrcImm),
        .fwdA(fwdA), .fwdB(fwdB), .memToRegW(memToRegW), .readData(readData),
        .zeroE(zeroE), .branchTarget(branchTarget),
        .aluResultM(aluResult), .writeDataM(writeData),
        .rdM(rdM), .rdW(wbRd), .resultW(wbData)
    );

endmodule : cpuCore

// ==== cpu_asserts.sv ====
// --------------------------------------------------
// cpuAsserts: stall, reset and flush rules of
// the pipeline control, bound to pipeControl
// --------------------------------------------------
`timescale 1ns/1ps

module cpuAsserts (
    input logic         clk,
    input logic         rst,
    input logic         stallF,
    input logic         memWrite,
    input logic         regWriteW,
    input logic         branchTaken,
    input cpuPkg::wordT instrD,
    input logic         regWriteE,
    input logic         memWriteE
);

    int failCount = 0;

    // load-use bubble clears the load out of execute
    stallOnce: assert property (@(posedge clk) disable iff (rst) stallF |=> !stallF)
        else begin
            failCount++;
            $error("stallF high for two cycles in a row");
        end

    resetQuiet: assert property (@(posedge clk) rst |=> (!memWrite && !regWriteW))
        else begin
            failCount++;
            $error("memWrite or regWriteW high right after reset");
        end

    // both younger instructions are gone one cycle later
    branchFlush: assert property (@(posedge clk) disable iff (rst)
                                  branchTaken |=> (instrD == '0 && !regWriteE && !memWriteE))
        else begin
            failCount++;
            $error("taken branch left an instruction in decode or execute");
        end

endmodule : cpuAsserts

bind pipeControl cpuAsserts u_asserts (
    .clk(clk), .rst(rst), .stallF(stallF), .memWrite(memWrite),
    .regWriteW(regWriteW), .branchTaken(branchTaken),
    .instrD(instrD), .regWriteE(regWriteE), .memWriteE(memWriteE)
);

// ==== cpuTb.sv ====
// --------------------------------------------------
// cpuTb: random program run on cpuCore and checked
// against an in-order instruction model
// --------------------------------------------------
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpuTb;

    localparam int progLen    = 64;
    localparam int progBody   = progLen - 7;      // tail stores x1..x7
    localparam int cycleLimit = 4 * progLen + 50;
    localparam int kindR = 0, kindI = 1, kindL = 2, kindS = 3, kindB = 4;
    localparam int fnAdd = 0, fnSub = 1, fnAnd = 2, fnOr = 3, fnSlt = 4;

    logic            clk, rst, memWrite, wbValid;
    cpuPkg::wordT    instr, readData, pc, aluResult, writeData, wbData, fetchIdx;
    cpuPkg::regAddrT wbRd;

    cpuPkg::wordT imem [progLen];
    cpuPkg::wordT dmem [16];
    int           kindA [progLen];
    int           fnA [progLen];
    logic [4:0]   rdA [progLen], rs1A [progLen], rs2A [progLen];
    cpuPkg::wordT immA [progLen];
    cpuPkg::wordT modelRegs [8];
    cpuPkg::wordT modelMem [16];
    cpuPkg::wordT expRd [$], expVal [$], expAddr [$], expData [$];
    integer       seed = 32'h46cf;
    int           errorCount = 0, checkCount = 0, cycleCount = 0;
    logic         timedOut = 1'b0;

    cpuCore i_dut (
        .clk(clk), .rst(rst), .instr(instr), .readData(readData), .pc(pc),
        .aluResult(aluResult), .writeData(writeData), .memWrite(memWrite),
        .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData)
    );

    // both memories answer in the same cycle
    assign fetchIdx = (pc - `CPU_RESET_PC) >> 2;
    assign instr    = (fetchIdx < progLen) ? imem[fetchIdx[5:0]] : '0;
    assign readData = dmem[aluResult[5:2]];

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic cpuPkg::wordT memFill(input int idx);
        return 32'h0badf00d ^ (32'(idx * 4) * 32'h01000193);
    endfunction

    function automatic cpuPkg::wordT aluModel(input int fn, input cpuPkg::wordT a, b);
        case (fn)
            fnSub:   return a - b;
            fnAnd:   return a & b;
            fnOr:    return a | b;
            fnSlt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return a + b;
        endcase
    endfunction

    function automatic logic [2:0] funct3Of(input int fn);
        case (fn)
            fnAnd:   return 3'b111;
            fnOr:    return 3'b110;
            fnSlt:   return 3'b010;
            default: return 3'b000;
        endcase
    endfunction

    task automatic putInstr(input int idx, input int kind, input int fn,
                            input logic [4:0] rd, rs1, rs2, input cpuPkg::wordT imm);
        logic [2:0] f3;
        f3          = funct3Of(fn);
        kindA[idx]  = kind;
        fnA[idx]    = fn;
        rdA[idx]    = rd;
        rs1A[idx]   = rs1;
        rs2A[idx]   = rs2;
        immA[idx]   = imm;
        case (kind)
            kindR:   imem[idx] = {((fn == fnSub) ? 7'h20 : 7'h00), rs2, rs1, f3, rd, `OP_RTYPE};
            kindI:   imem[idx] = {imm[11:0], rs1, f3, rd, `OP_ITYPE};
            kindL:   imem[idx] = {imm[11:0], rs1, 3'b010, rd, `OP_LOAD};
            kindS:   imem[idx] = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OP_STORE};
            default: imem[idx] = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11],
                                  `OP_BRANCH};
        endcase
    endtask

    task automatic genProgram;
        cpuPkg::wordT r, imm, off;
        int           idx, sel, target;
        logic [4:0]   rd, rs1, rs2;
        idx = 0;
        while (idx < progBody) begin
            r   = $random(seed);
            sel = int'(r[3:0]);
            rd  = {2'b00, r[10:8]};
            rs1 = {2'b00, r[13:11]};
            rs2 = {2'b00, r[16:14]};
            imm = {{20{r[31]}}, r[31:20]};
            off = {26'd0, r[19:16], 2'b00};
            if (sel < 5) begin
                putInstr(idx, kindR, int'(r[6:4]) % 5, rd, rs1, rs2, '0);
            end else if (sel < 9) begin
                putInstr(idx, kindI, (r[5:4] == 2'd1) ? fnSlt : int'(r[5:4]), rd, rs1, 5'd0, imm);
            end else if (sel < 11) begin
                putInstr(idx, kindL, fnAdd, rd, 5'd0, 5'd0, off);
                if (idx + 1 < progBody) begin   // consumer right behind the load
                    idx++;
                    if (r[7]) putInstr(idx, kindR, fnAdd, rs2, rd, rs1, '0);
                    else      putInstr(idx, kindR, fnSub, rs2, rs1, rd, '0);
                end
            end else if (sel < 13) begin
                putInstr(idx, kindS, fnAdd, 5'd0, 5'd0, rs2, off);
            end else begin
                target = idx + 1 + int'(r[5:4]);
                if (target > progBody) target = progBody;
                putInstr(idx, kindB, fnSub, 5'd0, rs1, r[6] ? rs1 : rs2, 32'((target - idx) * 4));
            end
            idx++;
        end
        for (int k = 1; k < 8; k++) begin
            putInstr(progBody + k - 1, kindS, fnAdd, 5'd0, 5'd0, 5'(k), 32'(4 * k));
        end
    endtask

    // in-order run, fills the expected write and store queues
    task automatic runModel;
        int           k, next;
        cpuPkg::wordT a, b, v, addr;
        for (int i = 0; i < 8; i++) modelRegs[i] = '0;
        for (int i = 0; i < 16; i++) modelMem[i] = memFill(i);
        k = 0;
        while (k < progLen) begin
            a    = modelRegs[rs1A[k][2:0]];
            b    = modelRegs[rs2A[k][2:0]];
            addr = a + immA[k];
            next = k + 1;
            case (kindA[k])
                kindR, kindI, kindL: begin
                    if (kindA[k] == kindR)      v = aluModel(fnA[k], a, b);
                    else if (kindA[k] == kindI) v = aluModel(fnA[k], a, immA[k]);
                    else                        v = modelMem[addr[5:2]];
                    expRd.push_back({27'd0, rdA[k]});
                    expVal.push_back(v);
                    if (rdA[k] != 5'd0) modelRegs[rdA[k][2:0]] = v;   // x0 stays zero
                end
                kindS: begin
                    expAddr.push_back(addr);
                    expData.push_back(b);
                    modelMem[addr[5:2]] = b;
                end
                default: if (a == b) next = k + int'(immA[k]) / 4;
            endcase
            k = next;
        end
    endtask

    task automatic checkValue(input string name, input cpuPkg::wordT expected, actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) dmem[i] <= memFill(i);
        end else begin
            cycleCount <= cycleCount + 1;
            if (memWrite) begin
                dmem[aluResult[5:2]] <= writeData;
                if (expAddr.size() == 0) begin
                    errorCount++;
                    $display("store to address %h that the model never made", aluResult);
                end else begin
                    checkValue("store address", expAddr.pop_front(), aluResult);
                    checkValue("store data", expData.pop_front(), writeData);
                end
            end
            if (wbValid) begin
                if (expVal.size() == 0) begin
                    errorCount++;
                    $display("register write to x%0d that the model never made", wbRd);
                end else begin
                    checkValue("writeback rd", expRd.pop_front(), {27'd0, wbRd});
                    checkValue("writeback data", expVal.pop_front(), wbData);
                end
            end
        end
    end

    initial begin
        rst <= 1'b1;
        genProgram();
        runModel();
        repeat (8) @(posedge clk);
        checkValue("reset pc", `CPU_RESET_PC, pc);
        rst <= 1'b0;
        while ((expVal.size() != 0 || expAddr.size() != 0) && cycleCount < cycleLimit) begin
            @(posedge clk);
        end
        if (expVal.size() != 0 || expAddr.size() != 0) begin
            timedOut = 1'b1;
            $display("timeout after %0d cycles, %0d writes and %0d stores never came",
                     cycleCount, expVal.size(), expAddr.size());
        end
        repeat (8) @(posedge clk);   // drain, catches stray events
        $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
                 checkCount, errorCount, i_dut.u_ctrl.u_asserts.failCount, timedOut);
        if (errorCount == 0 && i_dut.u_ctrl.u_asserts.failCount == 0 && !timedOut)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule : cpuTb

// ==== build.f ====
+incdir+.
cpuPkg.sv
pipeControl.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
cpuCore.sv
cpu_asserts.sv
cpuTb.sv

// ==== Makefile ====
# Verilator build and run of the cpuTb testbench
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run and check the log"
	@echo "make clean  remove obj_dir and the log"

test:
	verilator --binary --timing --assert --top-module cpuTb -f build.f
	./obj_dir/VcpuTb +verilator+error+limit+100 | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
